/* verilog/control_pkg.sv */
package control_pkg;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_ble   = 6'h06,
		op_bgt   = 6'h07,
		op_addi  = 6'h08,
		op_addiu = 6'h09,
		op_slti  = 6'h0a,
		op_lui   = 6'h0f,
		op_lb    = 6'h20,
		op_lh    = 6'h21,
		op_lw    = 6'h23,
		op_sb    = 6'h28,
		op_sh    = 6'h29,
		op_sw    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_sra  = 6'h03,
		fn_sllv = 6'h04,
		fn_srav = 6'h07,
		fn_jr   = 6'h08,
		fn_mfhi = 6'h10,
		fn_mflo = 6'h12,
		fn_add  = 6'h20,
		fn_sub  = 6'h22,
		fn_and  = 6'h24,
		fn_slt  = 6'h2a
	} funct_t;

	typedef struct packed {
		opcode_t opcode;
		funct_t  funct; // only meaningful for op_rtype
	} instr_fields_t;

	typedef struct packed {
		logic equal;
		logic greater; // reg A above reg B, signed
	} compare_flags_t;

	typedef enum logic [3:0] {
		cls_alu_reg, cls_alu_imm, cls_slt, cls_slti, cls_lui, cls_move_hi, cls_move_lo,
		cls_shift, cls_jump, cls_jump_reg, cls_jump_link, cls_branch, cls_load, cls_store
	} instr_class_t;

	typedef enum logic [2:0] {alu_pass, alu_add, alu_sub, alu_and, alu_compare} alu_op_t;

	typedef enum logic [2:0] {
		sh_none, sh_load, sh_left, sh_right_logic, sh_right_arith
	} shift_op_t;

	typedef enum logic [1:0] {br_equal, br_not_equal, br_less_equal, br_greater} branch_cond_t;
	typedef enum logic [1:0] {size_byte, size_half, size_word} access_size_t;
	typedef enum logic [1:0] {pc_from_alu, pc_from_alu_out, pc_from_target} pc_source_t;
	typedef enum logic {a_from_pc, a_from_reg_a} alu_a_t;
	typedef enum logic [1:0] {b_from_reg_b, b_from_four, b_from_imm} alu_b_t;
	typedef enum logic [1:0] {dst_rt, dst_rd, dst_link} reg_dst_t; // dst_link is r31

	typedef enum logic [2:0] {
		wb_alu_out, wb_upper_imm, wb_hi, wb_lo, wb_mdr, wb_shifter, wb_less_than
	} wb_source_t;

	typedef struct packed {
		instr_class_t instr_class;
		alu_op_t      alu_op;
		shift_op_t    shift_op;       // direction and kind of the shift step
		logic         shift_variable; // amount from rs instead of shamt
		branch_cond_t branch_cond;
		access_size_t access_size;
	} decoded_t;

	typedef struct packed {
		logic         pc_write;
		pc_source_t   pc_source;
		logic         ir_write;
		logic         mem_addr_from_alu_out; // else the PC addresses memory
		logic         mem_write;
		logic         mdr_write;
		access_size_t load_size;
		access_size_t store_size;
		alu_a_t       alu_a;
		alu_b_t       alu_b;
		alu_op_t      alu_op;
		logic         alu_out_write;
		logic         reg_a_write;
		logic         reg_b_write;
		logic         reg_write;
		reg_dst_t     reg_dst;
		wb_source_t   wb_source;
		shift_op_t    shift_op;
		logic         shift_variable;
	} ctrl_word_t;

	typedef enum logic [4:0] {
		st_reset, st_fetch, st_fetch_done, st_decode,
		st_execute, st_write_arith, st_write_direct,
		st_shift_load, st_shift_op, st_shift_write,
		st_jump, st_link, st_link_jump,
		st_branch_compare, st_branch_take,
		st_mem_addr, st_mem_wait, st_mem_read,
		st_load_extend, st_load_write, st_store_write,
		st_final
	} state_t;

endpackage

/* verilog/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
	input  control_pkg::instr_fields_t fields,
	output control_pkg::decoded_t      decoded
);
	import control_pkg::*;

	always_comb begin
		decoded.instr_class    = cls_alu_reg; // unknown codes fall back to and
		decoded.alu_op         = alu_and;
		decoded.shift_op       = sh_none;
		decoded.shift_variable = 1'b0;
		decoded.branch_cond    = br_equal;
		decoded.access_size    = size_word;

		case (fields.opcode)
			op_rtype: begin
				case (fields.funct)
					fn_add: decoded.alu_op = alu_add;
					fn_sub: decoded.alu_op = alu_sub;
					fn_and: decoded.alu_op = alu_and;
					fn_slt: begin
						decoded.instr_class = cls_slt;
						decoded.alu_op      = alu_compare;
					end
					fn_sll, fn_sllv: begin
						decoded.instr_class    = cls_shift;
						decoded.shift_op       = sh_left;
						decoded.shift_variable = (fields.funct == fn_sllv);
					end
					fn_srl: begin
						decoded.instr_class = cls_shift;
						decoded.shift_op    = sh_right_logic;
					end
					fn_sra, fn_srav: begin
						decoded.instr_class    = cls_shift;
						decoded.shift_op       = sh_right_arith;
						decoded.shift_variable = (fields.funct == fn_srav);
					end
					fn_jr: begin
						decoded.instr_class = cls_jump_reg;
						decoded.alu_op      = alu_pass; // rs straight through to pc
					end
					fn_mfhi: decoded.instr_class = cls_move_hi;
					fn_mflo: decoded.instr_class = cls_move_lo;
					default: ;
				endcase
			end
			op_j:   decoded.instr_class = cls_jump;
			op_jal: decoded.instr_class = cls_jump_link;
			op_beq, op_bne, op_ble, op_bgt: begin
				decoded.instr_class = cls_branch;
				decoded.alu_op      = alu_compare;
				decoded.branch_cond = branch_cond_t'(fields.opcode[1:0]); // 4..7 in order
			end
			op_addi, op_addiu: begin
				decoded.instr_class = cls_alu_imm;
				decoded.alu_op      = alu_add;
			end
			op_slti: begin
				decoded.instr_class = cls_slti;
				decoded.alu_op      = alu_compare;
			end
			op_lui: decoded.instr_class = cls_lui;
			op_lb, op_lh, op_lw, op_sb, op_sh, op_sw: begin
				decoded.instr_class = fields.opcode[3] ? cls_store : cls_load;
				decoded.alu_op      = alu_add; // base plus offset
				case (fields.opcode[1:0])
					2'b00:   decoded.access_size = size_byte;
					2'b01:   decoded.access_size = size_half;
					default: decoded.access_size = size_word;
				endcase
			end
			default: ;
		endcase
	end

endmodule

/* verilog/control_sequencer.sv */
`timescale 1ns/1ns

module control_sequencer #(
	parameter int fetch_wait_cycles = 1
) (
	input  logic                  clock,
	input  logic                  reset,
	input  control_pkg::decoded_t decoded,
	output control_pkg::state_t   state,
	output control_pkg::state_t   next_state,
	output control_pkg::decoded_t current
);
	import control_pkg::*;

	localparam int count_width = (fetch_wait_cycles > 0) ? $clog2(fetch_wait_cycles + 1) : 1;

	logic [count_width-1:0] wait_count;
	logic                   wait_done;

	// memory has delivered the instruction word
	assign wait_done = (wait_count == count_width'(fetch_wait_cycles));

	always_ff @(posedge clock) begin
		if (reset || state != st_fetch || wait_done) begin
			wait_count <= '0;
		end else begin
			wait_count <= wait_count + 1'b1;
		end
	end

	always_comb begin
		case (state)
			st_reset:      next_state = st_fetch;
			st_fetch:      next_state = wait_done ? st_fetch_done : st_fetch;
			st_fetch_done: next_state = st_decode;
			st_decode: begin
				// first state of each path, picked from the live decode
				case (decoded.instr_class)
					cls_alu_reg, cls_alu_imm: next_state = st_execute;
					cls_slt, cls_slti, cls_lui,
					cls_move_hi, cls_move_lo: next_state = st_write_direct;
					cls_shift:                next_state = st_shift_load;
					cls_jump, cls_jump_reg:   next_state = st_jump;
					cls_jump_link:            next_state = st_link;
					cls_branch:               next_state = st_branch_compare;
					cls_load, cls_store:      next_state = st_mem_addr;
					default:                  next_state = st_execute;
				endcase
			end
			st_execute:        next_state = st_write_arith;
			st_write_arith:    next_state = st_final;
			st_write_direct:   next_state = st_final;
			st_shift_load:     next_state = st_shift_op;
			st_shift_op:       next_state = st_shift_write;
			st_shift_write:    next_state = st_final;
			st_jump:           next_state = st_final;
			st_link:           next_state = st_link_jump;
			st_link_jump:      next_state = st_final;
			st_branch_compare: next_state = st_branch_take;
			st_branch_take:    next_state = st_final;
			st_mem_addr:       next_state = st_mem_wait;
			st_mem_wait:       next_state = st_mem_read;
			st_mem_read: begin
				// loads and stores share the address phase
				if (current.instr_class == cls_store) begin
					next_state = st_store_write;
				end else begin
					next_state = st_load_extend;
				end
			end
			st_load_extend:    next_state = st_load_write;
			st_load_write:     next_state = st_final;
			st_store_write:    next_state = st_final;
			st_final:          next_state = st_fetch;
			default:           next_state = st_reset;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_reset;
		end else begin
			state <= next_state;
		end
	end

	// instruction inputs may change after decode
	always_ff @(posedge clock) begin
		if (state == st_decode) begin
			current <= decoded;
		end
	end

endmodule

/* verilog/control_word_gen.sv */
`timescale 1ns/1ns

module control_word_gen (
	input  logic                        clock,
	input  logic                        reset,
	input  control_pkg::state_t         next_state,
	input  control_pkg::decoded_t       current,
	input  control_pkg::decoded_t       decoded,
	input  control_pkg::compare_flags_t flags,
	output control_pkg::ctrl_word_t     ctrl
);
	import control_pkg::*;

	decoded_t   record;
	logic       path_entry;
	logic       branch_taken;
	ctrl_word_t ctrl_next;

	// first states of a path are entered from st_decode, before current is loaded
	always_comb begin
		case (next_state)
			st_execute, st_write_direct, st_shift_load, st_jump,
			st_link, st_branch_compare, st_mem_addr: path_entry = 1'b1;
			default:                                 path_entry = 1'b0;
		endcase
	end

	assign record = path_entry ? decoded : current;

	always_comb begin
		case (record.branch_cond)
			br_equal:      branch_taken = flags.equal;
			br_not_equal:  branch_taken = !flags.equal;
			br_less_equal: branch_taken = !flags.greater;
			default:       branch_taken = flags.greater; // br_greater
		endcase
	end

	always_comb begin
		ctrl_next = '0;
		case (next_state)
			st_fetch: begin
				ctrl_next.ir_write = 1'b1;
				ctrl_next.alu_a    = a_from_pc; // pc + 4
				ctrl_next.alu_b    = b_from_four;
				ctrl_next.alu_op   = alu_add;
			end
			st_fetch_done: begin
				ctrl_next.pc_write  = 1'b1;
				ctrl_next.pc_source = pc_from_alu;
			end
			st_decode: begin
				ctrl_next.alu_out_write = 1'b1;
				ctrl_next.reg_a_write   = 1'b1; // rs
				ctrl_next.reg_b_write   = 1'b1; // rt
			end
			st_execute: begin
				ctrl_next.alu_a         = a_from_reg_a;
				ctrl_next.alu_b = (record.instr_class == cls_alu_imm) ? b_from_imm : b_from_reg_b;
				ctrl_next.alu_op        = record.alu_op;
				ctrl_next.alu_out_write = 1'b1;
			end
			st_write_arith: begin
				ctrl_next.reg_write = 1'b1;
				ctrl_next.reg_dst   = (record.instr_class == cls_alu_imm) ? dst_rt : dst_rd;
				ctrl_next.wb_source = wb_alu_out;
			end
			st_write_direct: begin
				ctrl_next.reg_write = 1'b1;
				case (record.instr_class)
					cls_slt, cls_slti: begin
						ctrl_next.reg_dst   = (record.instr_class == cls_slt) ? dst_rd : dst_rt;
						ctrl_next.wb_source = wb_less_than;
						ctrl_next.alu_a     = a_from_reg_a;
						ctrl_next.alu_b = (record.instr_class == cls_slt) ? b_from_reg_b : b_from_imm;
						ctrl_next.alu_op    = alu_compare;
					end
					cls_lui: begin
						ctrl_next.reg_dst   = dst_rt;
						ctrl_next.wb_source = wb_upper_imm;
					end
					cls_move_hi: begin
						ctrl_next.reg_dst   = dst_rd;
						ctrl_next.wb_source = wb_hi;
					end
					default: begin
						ctrl_next.reg_dst   = dst_rd; // mflo
						ctrl_next.wb_source = wb_lo;
					end
				endcase
			end
			st_shift_load: begin
				ctrl_next.shift_op       = sh_load;
				ctrl_next.shift_variable = record.shift_variable;
			end
			st_shift_op: ctrl_next.shift_op = record.shift_op;
			st_shift_write: begin
				ctrl_next.reg_write = 1'b1;
				ctrl_next.reg_dst   = dst_rd;
				ctrl_next.wb_source = wb_shifter;
			end
			st_jump: begin
				ctrl_next.pc_write = 1'b1;
				if (record.instr_class == cls_jump_reg) begin
					ctrl_next.pc_source = pc_from_alu;
					ctrl_next.alu_a     = a_from_reg_a;
					ctrl_next.alu_op    = alu_pass;
				end else begin
					ctrl_next.pc_source = pc_from_target;
				end
			end
			st_link: begin
				ctrl_next.alu_out_write = 1'b1; // return address
				ctrl_next.alu_a         = a_from_pc;
				ctrl_next.alu_op        = alu_pass;
			end
			st_link_jump: begin
				ctrl_next.reg_write = 1'b1;
				ctrl_next.reg_dst   = dst_link;
				ctrl_next.wb_source = wb_alu_out;
				ctrl_next.pc_write  = 1'b1;
				ctrl_next.pc_source = pc_from_target;
			end
			st_branch_compare: begin
				ctrl_next.alu_a  = a_from_reg_a;
				ctrl_next.alu_b  = b_from_reg_b;
				ctrl_next.alu_op = alu_compare;
			end
			st_branch_take: begin
				ctrl_next.pc_source = pc_from_alu_out; // target computed in decode
				ctrl_next.pc_write  = branch_taken;
			end
			st_mem_addr: begin
				ctrl_next.mem_addr_from_alu_out = 1'b1;
				ctrl_next.alu_a                 = a_from_reg_a;
				ctrl_next.alu_b                 = b_from_imm;
				ctrl_next.alu_op                = alu_add;
				ctrl_next.alu_out_write         = 1'b1;
			end
			st_mem_wait: ctrl_next.mem_addr_from_alu_out = 1'b1;
			st_mem_read: begin
				ctrl_next.mem_addr_from_alu_out = 1'b1;
				ctrl_next.mdr_write             = 1'b1;
			end
			st_load_extend: ctrl_next.load_size = record.access_size;
			st_load_write: begin
				ctrl_next.reg_write = 1'b1;
				ctrl_next.reg_dst   = dst_rt;
				ctrl_next.wb_source = wb_mdr;
			end
			st_store_write: begin
				ctrl_next.mem_addr_from_alu_out = 1'b1;
				ctrl_next.mem_write             = 1'b1;
				ctrl_next.store_size            = record.access_size; // merge into mdr word
			end
			default: ; // st_reset and st_final stay idle
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl <= '0;
		end else begin
			ctrl <= ctrl_next;
		end
	end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ns

module control_unit #(
	parameter int fetch_wait_cycles = 1
) (
	input  logic                        clock,
	input  logic                        reset,
	input  control_pkg::instr_fields_t  fields,
	input  control_pkg::compare_flags_t flags,
	output control_pkg::ctrl_word_t     ctrl,
	output control_pkg::state_t         state
);
	import control_pkg::*;

	decoded_t decoded; // live, from the current ir fields
	decoded_t current; // held from st_decode on
	state_t   next_state;

	instr_decoder instr_decoder_inst (
		.fields  (fields),
		.decoded (decoded)
	);

	control_sequencer #(
		.fetch_wait_cycles (fetch_wait_cycles)
	) control_sequencer_inst (
		.clock      (clock),
		.reset      (reset),
		.decoded    (decoded),
		.state      (state),
		.next_state (next_state),
		.current    (current)
	);

	control_word_gen control_word_gen_inst (
		.clock      (clock),
		.reset      (reset),
		.next_state (next_state),
		.current    (current),
		.decoded    (decoded),
		.flags      (flags),
		.ctrl       (ctrl)
	);

endmodule

/* include/control_model.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// class of an instruction as the controller should see it
function automatic control_pkg::instr_class_t model_class(control_pkg::instr_fields_t f);
	control_pkg::instr_class_t cls;
	cls = control_pkg::cls_alu_reg; // unknown codes run as and
	case (f.opcode)
		control_pkg::op_rtype: begin
			case (f.funct)
				control_pkg::fn_slt:  cls = control_pkg::cls_slt;
				control_pkg::fn_sll, control_pkg::fn_srl, control_pkg::fn_sra,
				control_pkg::fn_sllv, control_pkg::fn_srav: cls = control_pkg::cls_shift;
				control_pkg::fn_jr:   cls = control_pkg::cls_jump_reg;
				control_pkg::fn_mfhi: cls = control_pkg::cls_move_hi;
				control_pkg::fn_mflo: cls = control_pkg::cls_move_lo;
				default: ;
			endcase
		end
		control_pkg::op_j:   cls = control_pkg::cls_jump;
		control_pkg::op_jal: cls = control_pkg::cls_jump_link;
		control_pkg::op_beq, control_pkg::op_bne,
		control_pkg::op_ble, control_pkg::op_bgt: cls = control_pkg::cls_branch;
		control_pkg::op_addi, control_pkg::op_addiu: cls = control_pkg::cls_alu_imm;
		control_pkg::op_slti: cls = control_pkg::cls_slti;
		control_pkg::op_lui:  cls = control_pkg::cls_lui;
		control_pkg::op_lb, control_pkg::op_lh, control_pkg::op_lw: cls = control_pkg::cls_load;
		control_pkg::op_sb, control_pkg::op_sh, control_pkg::op_sw: cls = control_pkg::cls_store;
		default: ;
	endcase
	return cls;
endfunction

// number of states after st_decode per class including st_final
localparam int path_length [14] = '{3, 3, 2, 2, 2, 2, 2, 4, 2, 2, 3, 3, 6, 5};

// write-back target per class where writes_reg is set
localparam bit writes_reg [14] = '{1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 1, 0, 1, 0};
localparam control_pkg::reg_dst_t expected_dst [14] = '{
	control_pkg::dst_rd, control_pkg::dst_rt, control_pkg::dst_rd, control_pkg::dst_rt,
	control_pkg::dst_rt, control_pkg::dst_rd, control_pkg::dst_rd, control_pkg::dst_rd,
	control_pkg::dst_rt, control_pkg::dst_rt, control_pkg::dst_link, control_pkg::dst_rt,
	control_pkg::dst_rt, control_pkg::dst_rt
};
localparam control_pkg::wb_source_t expected_wb [14] = '{
	control_pkg::wb_alu_out, control_pkg::wb_alu_out, control_pkg::wb_less_than,
	control_pkg::wb_less_than, control_pkg::wb_upper_imm, control_pkg::wb_hi, control_pkg::wb_lo,
	control_pkg::wb_shifter, control_pkg::wb_alu_out, control_pkg::wb_alu_out,
	control_pkg::wb_alu_out, control_pkg::wb_alu_out, control_pkg::wb_mdr, control_pkg::wb_alu_out
};

function automatic control_pkg::access_size_t model_size(control_pkg::opcode_t op);
	case (op)
		control_pkg::op_lb, control_pkg::op_sb: return control_pkg::size_byte;
		control_pkg::op_lh, control_pkg::op_sh: return control_pkg::size_half;
		default:                                return control_pkg::size_word;
	endcase
endfunction

// execute step operation for the alu_reg and alu_imm classes
function automatic control_pkg::alu_op_t model_alu_op(control_pkg::instr_fields_t f);
	case (f.opcode)
		control_pkg::op_addi, control_pkg::op_addiu: return control_pkg::alu_add;
		control_pkg::op_rtype: begin
			if (f.funct == control_pkg::fn_add)
				return control_pkg::alu_add;
			if (f.funct == control_pkg::fn_sub)
				return control_pkg::alu_sub;
			return control_pkg::alu_and;
		end
		default: return control_pkg::alu_and;
	endcase
endfunction

// shift kind of sll, srl, sra, sllv and srav
function automatic control_pkg::shift_op_t model_shift(control_pkg::funct_t fn);
	case (fn)
		control_pkg::fn_sll, control_pkg::fn_sllv: return control_pkg::sh_left;
		control_pkg::fn_srl:                       return control_pkg::sh_right_logic;
		default:                                   return control_pkg::sh_right_arith;
	endcase
endfunction

// amount comes from rs for sllv and srav
function automatic bit model_shift_variable(control_pkg::funct_t fn);
	return (fn == control_pkg::fn_sllv) || (fn == control_pkg::fn_srav);
endfunction

// branch outcome from the opcode and the flags of the compare cycle
function automatic bit model_taken(control_pkg::opcode_t op, control_pkg::compare_flags_t fl);
	case (op)
		control_pkg::op_beq: return fl.equal;
		control_pkg::op_bne: return !fl.equal;
		control_pkg::op_ble: return !fl.greater;
		default:             return fl.greater;
	endcase
endfunction

`endif

/* tests/control_unit_tb.sv */
`timescale 1ns/1ns

module control_unit_tb;
	import control_pkg::*;

	`include "control_model.svh"

	localparam int num_instrs = 400;
	localparam int max_cycles = num_instrs * 11 + 50; // longest path is 10 cycles

	localparam opcode_t kept_ops [17] = '{
		op_rtype, op_j, op_jal, op_beq, op_bne, op_ble, op_bgt, op_addi, op_addiu,
		op_slti, op_lui, op_lb, op_lh, op_lw, op_sb, op_sh, op_sw
	};
	localparam funct_t kept_functs [12] = '{
		fn_sll, fn_srl, fn_sra, fn_sllv, fn_srav, fn_jr,
		fn_mfhi, fn_mflo, fn_add, fn_sub, fn_and, fn_slt
	};
	localparam logic [5:0] unknown_ops [3] = '{6'h01, 6'h1c, 6'h3f};
	localparam logic [5:0] unknown_functs [3] = '{6'h0d, 6'h18, 6'h1a}; // dropped break, mult, div

	logic           clock;
	logic           reset;
	instr_fields_t  fields;
	compare_flags_t flags;
	ctrl_word_t     ctrl;
	state_t         state;

	int mismatch_count = 0;
	int other_errors = 0;
	int cycle_count = 0;
	int issued = 0;
	int completed = 0;

	// monitor bookkeeping for one instruction at a time
	state_t         prev_state = st_reset;
	compare_flags_t prev_flags = '0;
	bit             active = 1'b0;
	bit             after_reset = 1'b0;
	instr_fields_t  cur_fields;
	instr_class_t   cur_class = cls_alu_reg;
	int             cycles;
	int             ir_count;
	int             reg_count;
	int             mdr_count;
	int             mem_count;
	int             load_count;

	control_unit #(
		.fetch_wait_cycles (1)
	) control_unit_inst (
		.clock  (clock),
		.reset  (reset),
		.fields (fields),
		.flags  (flags),
		.ctrl   (ctrl),
		.state  (state)
	);

	always #2 clock = ~clock;

	task automatic report_mismatch(string name, int actual, int expected);
		mismatch_count++;
		$display("mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
	endtask

	// mostly kept instructions plus a few unknown codes that run as and
	function automatic instr_fields_t random_instr();
		instr_fields_t f;
		int            roll;
		roll = $urandom_range(99);
		f.opcode = op_rtype;
		f.funct  = fn_and;
		if (roll < 3) begin
			f.opcode = opcode_t'(unknown_ops[$urandom_range(2)]);
			f.funct  = funct_t'($urandom_range(63));
		end else if (roll < 6) begin
			f.funct = funct_t'(unknown_functs[$urandom_range(2)]);
		end else if (roll < 45) begin
			f.funct = kept_functs[$urandom_range(11)];
		end else begin
			f.opcode = kept_ops[$urandom_range(16)];
			f.funct  = funct_t'($urandom_range(63)); // don't care outside r-type
		end
		return f;
	endfunction

	// totals of one instruction at the start of the next fetch
	task automatic check_instr_totals();
		bit is_load;
		bit is_store;
		is_load  = (cur_class == cls_load);
		is_store = (cur_class == cls_store);
		if (cycles != 4 + path_length[cur_class])
			report_mismatch("cycles per instruction", cycles, 4 + path_length[cur_class]);
		if (ir_count != 2)
			report_mismatch("ir_write cycles", ir_count, 2);
		if (reg_count != int'(writes_reg[cur_class]))
			report_mismatch("reg_write cycles", reg_count, int'(writes_reg[cur_class]));
		if (mdr_count != int'(is_load || is_store))
			report_mismatch("mdr_write cycles", mdr_count, int'(is_load || is_store));
		if (mem_count != int'(is_store))
			report_mismatch("mem_write cycles", mem_count, int'(is_store));
		if (load_count != int'(is_load))
			report_mismatch("st_load_extend cycles", load_count, int'(is_load));
	endtask

	initial begin
		void'($urandom(32'h91cb7fab));
		clock  = 1'b0;
		reset  = 1'b1;
		fields = '{opcode: op_rtype, funct: fn_and};
		flags  = '0;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		while (completed < num_instrs) begin
			@(posedge clock);
			#1;
			flags = compare_flags_t'($urandom_range(3));
			if (state == st_fetch_done && issued < num_instrs) begin
				fields = random_instr(); // held until the next fetch_done
				issued++;
			end
		end
		$display("%0d instructions checked, %0d mismatches, %0d other errors",
			completed, mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			other_errors++;
			$display("timeout: only %0d of %0d instructions finished within %0d cycles",
				completed, num_instrs, max_cycles);
			$display("%0d instructions checked, %0d mismatches, %0d other errors",
				completed, mismatch_count, other_errors);
			$display("Errors found");
			$finish;
		end
	end

	// outputs sampled at the falling edge
	always @(negedge clock) begin
		if (reset) begin
			if (state !== st_reset) report_mismatch("state", state, st_reset);
			if (ctrl !== '0) report_mismatch("ctrl", ctrl, 0);
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				if (state !== st_reset) report_mismatch("state", state, st_reset);
				after_reset = 1'b0;
			end else if (prev_state == st_reset && state !== st_fetch) begin
				report_mismatch("state", state, st_fetch);
			end
			if (state == st_reset && ctrl !== '0) report_mismatch("ctrl", ctrl, 0);

			if (state == st_fetch && prev_state != st_fetch) begin
				if (active) begin
					check_instr_totals();
					completed++;
				end
				active     = 1'b1;
				cycles     = 0;
				ir_count   = 0;
				reg_count  = 0;
				mdr_count  = 0;
				mem_count  = 0;
				load_count = 0;
			end

			if (active) begin
				cycles++;
				if (state == st_decode) begin
					cur_fields = fields;
					cur_class  = model_class(fields);
				end
				if (ctrl.ir_write) ir_count++;
				if (ctrl.mdr_write) mdr_count++;
				if (ctrl.reg_write) begin
					reg_count++;
					if (ctrl.reg_dst !== expected_dst[cur_class])
						report_mismatch("ctrl.reg_dst", ctrl.reg_dst, expected_dst[cur_class]);
					if (ctrl.wb_source !== expected_wb[cur_class])
						report_mismatch("ctrl.wb_source", ctrl.wb_source, expected_wb[cur_class]);
				end
				if (state == st_fetch_done) begin
					if (ctrl.pc_write !== 1'b1) report_mismatch("ctrl.pc_write", ctrl.pc_write, 1);
					if (ctrl.pc_source !== pc_from_alu)
						report_mismatch("ctrl.pc_source", ctrl.pc_source, pc_from_alu);
				end
				if (state == st_execute && ctrl.alu_op !== model_alu_op(cur_fields))
					report_mismatch("ctrl.alu_op", ctrl.alu_op, model_alu_op(cur_fields));
				if (state == st_shift_load) begin
					if (ctrl.shift_op !== sh_load)
						report_mismatch("ctrl.shift_op", ctrl.shift_op, sh_load);
					if (ctrl.shift_variable !== model_shift_variable(cur_fields.funct))
						report_mismatch("ctrl.shift_variable", ctrl.shift_variable,
							model_shift_variable(cur_fields.funct));
				end
				if (state == st_shift_op && ctrl.shift_op !== model_shift(cur_fields.funct))
					report_mismatch("ctrl.shift_op", ctrl.shift_op,
						model_shift(cur_fields.funct));
				if (state == st_branch_take) begin
					// condition comes from the flags seen in st_branch_compare
					if (ctrl.pc_write !== model_taken(cur_fields.opcode, prev_flags))
						report_mismatch("ctrl.pc_write", ctrl.pc_write,
							model_taken(cur_fields.opcode, prev_flags));
					if (ctrl.pc_source !== pc_from_alu_out)
						report_mismatch("ctrl.pc_source", ctrl.pc_source, pc_from_alu_out);
				end
				if (ctrl.mem_write) begin
					mem_count++;
					if (ctrl.store_size !== model_size(cur_fields.opcode))
						report_mismatch("ctrl.store_size", ctrl.store_size,
							model_size(cur_fields.opcode));
				end
				if (state == st_load_extend) begin
					load_count++;
					if (ctrl.load_size !== model_size(cur_fields.opcode))
						report_mismatch("ctrl.load_size", ctrl.load_size,
							model_size(cur_fields.opcode));
				end
			end
		end
		prev_state = state;
		prev_flags = flags;
	end

endmodule

/* sim.f */
+incdir+include
verilog/control_pkg.sv
verilog/instr_decoder.sv
verilog/control_sequencer.sv
verilog/control_word_gen.sv
verilog/control_unit.sv
tests/control_unit_tb.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - verilog/control_pkg.sv
  - verilog/instr_decoder.sv
  - verilog/control_sequencer.sv
  - verilog/control_word_gen.sv
  - verilog/control_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/control_unit_tb.sv
